// ==== logic/zxuno_consts.svh ====
`ifndef ZXUNO_CONSTS_SVH
`define ZXUNO_CONSTS_SVH

// ------------------------------------------------------------
// Indexed register port pair
// ------------------------------------------------------------
`define ZX_ADDR_PORT    16'hFC3B
`define ZX_DATA_PORT    16'hFD3B

// Register numbers behind FD3B
`define ZX_REG_DEVOPT   8'h0E
`define ZX_REG_SCRATCH  8'hFE
`define ZX_REG_COREID   8'hFF

// Core id string length, terminator included
`define ZX_COREID_LEN   8

// Register reset values
`define ZX_SCRATCH_RST  8'h00
`define ZX_DEVOPT_RST   8'h00

// Floating data bus
`define ZX_BUS_IDLE     8'hFF

`endif

// ==== logic/zxuno_bus_pkg.sv ====
package zxuno_bus_pkg;

  // ------------------------------------------------------------
  // Z80 bus types
  // ------------------------------------------------------------

  // Full 16-bit I/O or memory address
  typedef logic [15:0] cpu_addr_t;

  // One byte on the data bus, either direction
  typedef logic [7:0] cpu_data_t;

  // Register number latched through FC3B
  typedef logic [7:0] zxreg_num_t;

endpackage

// ==== logic/zxuno_cfg_pkg.sv ====
package zxuno_cfg_pkg;

  // ------------------------------------------------------------
  // Configuration register types
  // ------------------------------------------------------------

  // Device options byte
  // Only disable_ay steers logic, the rest is plain storage
  typedef struct packed {
    logic [6:0] reserved_opts;
    logic       disable_ay;
  } devopt_t;

  // Character position inside the core id string
  typedef logic [2:0] coreid_idx_t;

endpackage

// ==== logic/zxuno_regaddr.sv ====
`timescale 1ns/1ns
`include "zxuno_consts.svh"

module zxuno_regaddr (
  input  logic                     sysclk,
  input  logic                     rst_n,
  input  zxuno_bus_pkg::cpu_addr_t cpu_addr,
  input  zxuno_bus_pkg::cpu_data_t cpu_dout,
  input  logic                     iorq_n,
  input  logic                     rd_n,
  input  logic                     wr_n,
  output zxuno_bus_pkg::zxreg_num_t reg_num,
  output logic                     reg_rd,
  output logic                     reg_wr,
  output logic                     reg_num_changed,
  output logic                     addr_oe
);

  logic addr_sel;
  logic data_sel;
  logic addr_wr;
  logic data_wr;
  logic addr_wr_q;
  logic data_wr_q;

  // ------------------------------------------------------------
  // Port decode
  // ------------------------------------------------------------
  assign addr_sel = (cpu_addr == `ZX_ADDR_PORT);
  assign data_sel = (cpu_addr == `ZX_DATA_PORT);

  assign addr_wr = !iorq_n && !wr_n && addr_sel;
  assign data_wr = !iorq_n && !wr_n && data_sel;

  // Reads are plain levels for the whole bus cycle
  assign addr_oe = !iorq_n && !rd_n && addr_sel;
  assign reg_rd  = !iorq_n && !rd_n && data_sel;

  // Previous strobe state for edge detection
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      addr_wr_q <= 1'b0;
      data_wr_q <= 1'b0;
    end else begin
      addr_wr_q <= addr_wr;
      data_wr_q <= data_wr;
    end
  end

  // ------------------------------------------------------------
  // Register number latch
  // ------------------------------------------------------------
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      reg_num         <= '0;
      reg_num_changed <= 1'b0;
    end else begin
      reg_num_changed <= 1'b0;
      // Only the first edge of a write cycle loads
      if (addr_wr && !addr_wr_q) begin
        reg_num         <= cpu_dout;
        reg_num_changed <= 1'b1;
      end
    end
  end

  // One write strobe per FD3B cycle, however long it lasts
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      reg_wr <= 1'b0;
    end else begin
      reg_wr <= data_wr && !data_wr_q;
    end
  end

endmodule

// ==== logic/zxuno_cfg_reg.sv ====
`timescale 1ns/1ns

module zxuno_cfg_reg #(
  parameter type                        payload_t = zxuno_bus_pkg::cpu_data_t,
  parameter zxuno_bus_pkg::zxreg_num_t  REG_NUM   = 8'h00
) (
  input  logic                      sysclk,
  input  logic                      rst_n,
  input  zxuno_bus_pkg::zxreg_num_t reg_num,
  input  logic                      reg_rd,
  input  logic                      reg_wr,
  input  zxuno_bus_pkg::cpu_data_t  cpu_dout,
  output payload_t                  value,
  output zxuno_bus_pkg::cpu_data_t  rd_data,
  output logic                      oe
);

  logic hit;

  // Selected through FC3B
  assign hit = (reg_num == REG_NUM);

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      value <= '0;
    end else if (reg_wr && hit) begin
      value <= payload_t'(cpu_dout);
    end
  end

  // ------------------------------------------------------------
  // Read back, all bits as stored
  // ------------------------------------------------------------
  assign rd_data = zxuno_bus_pkg::cpu_data_t'(value);
  assign oe      = reg_rd && hit;

endmodule

// ==== logic/coreid_rom.sv ====
`timescale 1ns/1ns
`include "zxuno_consts.svh"

module coreid_rom (
  input  logic                      sysclk,
  input  logic                      rst_n,
  input  zxuno_bus_pkg::zxreg_num_t reg_num,
  input  logic                      reg_rd,
  input  logic                      reg_num_changed,
  output zxuno_bus_pkg::cpu_data_t  rd_data,
  output logic                      oe
);

  localparam zxuno_cfg_pkg::coreid_idx_t LAST_IDX =
    zxuno_cfg_pkg::coreid_idx_t'(`ZX_COREID_LEN - 1);

  zxuno_cfg_pkg::coreid_idx_t idx;
  logic                       rd_hit;
  logic                       rd_hit_q;

  assign rd_hit = reg_rd && (reg_num == `ZX_REG_COREID);
  assign oe     = rd_hit;

  // ------------------------------------------------------------
  // String "ZXIO-01" and its terminator
  // ------------------------------------------------------------
  always_comb begin
    case (idx)
      3'd0:    rd_data = "Z";
      3'd1:    rd_data = "X";
      3'd2:    rd_data = "I";
      3'd3:    rd_data = "O";
      3'd4:    rd_data = "-";
      3'd5:    rd_data = "0";
      3'd6:    rd_data = "1";
      default: rd_data = 8'h00;
    endcase
  end

  // ------------------------------------------------------------
  // Index moves on when a read of FF ends
  // ------------------------------------------------------------
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      idx      <= '0;
      rd_hit_q <= 1'b0;
    end else begin
      rd_hit_q <= rd_hit;
      if (reg_num_changed) begin
        // New register number restarts the string
        idx <= '0;
      end else if (rd_hit_q && !rd_hit) begin
        if (idx == LAST_IDX) begin
          idx <= '0;
        end else begin
          idx <= idx + 3'd1;
        end
      end
    end
  end

endmodule

// ==== logic/ay_bus_ctrl.sv ====
`timescale 1ns/1ns

module ay_bus_ctrl (
  input  zxuno_bus_pkg::cpu_addr_t cpu_addr,
  input  logic                     iorq_n,
  input  logic                     rd_n,
  input  logic                     wr_n,
  input  logic                     disable_ay,
  output logic                     bdir,
  output logic                     bc1
);

  // ------------------------------------------------------------
  // AY bus modes, BC2 tied high outside
  //   bdir bc1  mode
  //    0    0   inactive
  //    0    1   read       rd FFFD, rd F6
  //    1    0   write      wr BFFD, wr F6
  //    1    1   latch      wr FFFD, wr F5
  // ------------------------------------------------------------

  logic port_bffd;
  logic port_fffd;
  logic port_f5;
  logic port_f6;
  logic io_wr;
  logic io_rd;

  // Partial decode as on the original Spectrum 128
  assign port_bffd = cpu_addr[15] && (cpu_addr[1:0] == 2'b01);
  assign port_fffd = cpu_addr[15] && cpu_addr[14] && (cpu_addr[1:0] == 2'b01);

  // Timex ports, low byte only
  assign port_f5 = (cpu_addr[7:0] == 8'hF5);
  assign port_f6 = (cpu_addr[7:0] == 8'hF6);

  // Chip disabled looks like no I/O at all
  assign io_wr = !iorq_n && !wr_n && !disable_ay;
  assign io_rd = !iorq_n && !rd_n && !disable_ay;

  assign bdir = io_wr && (port_bffd || port_fffd || port_f5 || port_f6);
  assign bc1  = (io_wr && (port_fffd || port_f5)) || (io_rd && (port_fffd || port_f6));

endmodule

// ==== logic/zxuno_io_top.sv ====
`timescale 1ns/1ns
`include "zxuno_consts.svh"

module zxuno_io_top (
  input  logic                     sysclk,
  input  logic                     rst_n,
  input  zxuno_bus_pkg::cpu_addr_t cpu_addr,
  input  zxuno_bus_pkg::cpu_data_t cpu_dout,
  input  logic                     iorq_n,
  input  logic                     rd_n,
  input  logic                     wr_n,
  input  logic                     m1_n,
  output zxuno_bus_pkg::cpu_data_t cpu_din,
  output logic                     bdir,
  output logic                     bc1
);

  // Register address port
  zxuno_bus_pkg::zxreg_num_t reg_num;
  logic                      reg_rd;
  logic                      reg_wr;
  logic                      reg_num_changed;
  logic                      addr_oe;

  // Register read paths
  zxuno_bus_pkg::cpu_data_t  scratch_data;
  logic                      scratch_oe;
  zxuno_bus_pkg::cpu_data_t  devopt_data;
  logic                      devopt_oe;
  zxuno_cfg_pkg::devopt_t    devopt;
  zxuno_bus_pkg::cpu_data_t  coreid_data;
  logic                      coreid_oe;

  // Interrupt acknowledge puts FF on the bus
  logic                      int_ack;

  assign int_ack = !iorq_n && !m1_n;

  // ------------------------------------------------------------
  // CPU data input, highest priority first
  // ------------------------------------------------------------
  always_comb begin
    case (1'b1)
      int_ack:    cpu_din = 8'hFF;
      addr_oe:    cpu_din = reg_num;
      coreid_oe:  cpu_din = coreid_data;
      devopt_oe:  cpu_din = devopt_data;
      scratch_oe: cpu_din = scratch_data;
      default:    cpu_din = `ZX_BUS_IDLE;
    endcase
  end

  zxuno_regaddr zxuno_regaddr_i (
    .sysclk          (sysclk         ),
    .rst_n           (rst_n          ),
    .cpu_addr        (cpu_addr       ),
    .cpu_dout        (cpu_dout       ),
    .iorq_n          (iorq_n         ),
    .rd_n            (rd_n           ),
    .wr_n            (wr_n           ),
    .reg_num         (reg_num        ),
    .reg_rd          (reg_rd         ),
    .reg_wr          (reg_wr         ),
    .reg_num_changed (reg_num_changed),
    .addr_oe         (addr_oe        )
  );

  zxuno_cfg_reg #(
    .payload_t (zxuno_bus_pkg::cpu_data_t),
    .REG_NUM   (`ZX_REG_SCRATCH          )
  ) scratch_i (
    .sysclk   (sysclk      ),
    .rst_n    (rst_n       ),
    .reg_num  (reg_num     ),
    .reg_rd   (reg_rd      ),
    .reg_wr   (reg_wr      ),
    .cpu_dout (cpu_dout    ),
    .value    (            ),
    .rd_data  (scratch_data),
    .oe       (scratch_oe  )
  );

  zxuno_cfg_reg #(
    .payload_t (zxuno_cfg_pkg::devopt_t),
    .REG_NUM   (`ZX_REG_DEVOPT         )
  ) devopt_i (
    .sysclk   (sysclk     ),
    .rst_n    (rst_n      ),
    .reg_num  (reg_num    ),
    .reg_rd   (reg_rd     ),
    .reg_wr   (reg_wr     ),
    .cpu_dout (cpu_dout   ),
    .value    (devopt     ),
    .rd_data  (devopt_data),
    .oe       (devopt_oe  )
  );

  coreid_rom coreid_rom_i (
    .sysclk          (sysclk         ),
    .rst_n           (rst_n          ),
    .reg_num         (reg_num        ),
    .reg_rd          (reg_rd         ),
    .reg_num_changed (reg_num_changed),
    .rd_data         (coreid_data    ),
    .oe              (coreid_oe      )
  );

  // External AY, steered by the device options
  ay_bus_ctrl ay_bus_ctrl_i (
    .cpu_addr   (cpu_addr         ),
    .iorq_n     (iorq_n           ),
    .rd_n       (rd_n             ),
    .wr_n       (wr_n             ),
    .disable_ay (devopt.disable_ay),
    .bdir       (bdir             ),
    .bc1        (bc1              )
  );

endmodule

// ==== verif/zxuno_io_assert.sv ====
`timescale 1ns/1ns

module zxuno_io_assert (
  input logic sysclk,
  input logic rst_n,
  input logic iorq_n,
  input logic reg_wr,
  input logic disable_ay,
  input logic bdir,
  input logic bc1
);

  int violations = 0;

  // ------------------------------------------------------------
  // AY bus control
  // ------------------------------------------------------------
  ay_quiet_without_iorq: assert property (
    @(posedge sysclk) disable iff (!rst_n) iorq_n |-> (!bdir && !bc1)
  ) else begin
    violations = violations + 1;
    $error("AY bus active while iorq_n is high");
  end

  ay_quiet_when_disabled: assert property (
    @(posedge sysclk) disable iff (!rst_n) disable_ay |-> (!bdir && !bc1)
  ) else begin
    violations = violations + 1;
    $error("AY bus active while disable_ay is set");
  end

  // Register write strobe
  reg_wr_single_cycle: assert property (
    @(posedge sysclk) disable iff (!rst_n) reg_wr |=> !reg_wr
  ) else begin
    violations = violations + 1;
    $error("reg_wr held high for more than one cycle");
  end

endmodule

// ==== verif/zxuno_io_checker.sv ====
`timescale 1ns/1ns

module zxuno_io_checker (
  input  logic                     sysclk,
  input  logic                     sample,
  input  logic [127:0]             test_name,
  input  zxuno_bus_pkg::cpu_data_t exp_din,
  input  logic                     exp_bdir,
  input  logic                     exp_bc1,
  input  zxuno_bus_pkg::cpu_data_t cpu_din,
  input  logic                     bdir,
  input  logic                     bc1,
  output int                       pass_count,
  output int                       fail_count
);

  int   passes = 0;
  int   fails  = 0;
  logic match;

  assign pass_count = passes;
  assign fail_count = fails;

  // ------------------------------------------------------------
  // Compare at the second falling edge of each bus cycle
  // ------------------------------------------------------------
  // Strobes of this cycle are still up here, release lands after the sample
  always @(negedge sysclk) begin
    if (sample) begin
      match = (cpu_din === exp_din) && (bdir === exp_bdir) && (bc1 === exp_bc1);
      if (match) begin
        passes = passes + 1;
        $display("pass  %0s", test_name);
      end else begin
        fails = fails + 1;
        $display("error %0s expected din=%02h bdir=%b bc1=%b actual din=%02h bdir=%b bc1=%b",
                 test_name, exp_din, exp_bdir, exp_bc1, cpu_din, bdir, bc1);
      end
    end
  end

endmodule

// ==== verif/zxuno_io_tb.sv ====
`timescale 1ns/1ns

module zxuno_io_tb;

  localparam int MAX_TESTS = 64;

  localparam logic [1:0] OP_WR   = 2'd0;
  localparam logic [1:0] OP_RD   = 2'd1;
  localparam logic [1:0] OP_ACK  = 2'd2;
  localparam logic [1:0] OP_IDLE = 2'd3;

  logic                     sysclk = 1'b0;
  logic                     rst_n;
  zxuno_bus_pkg::cpu_addr_t cpu_addr;
  zxuno_bus_pkg::cpu_data_t cpu_dout;
  logic                     iorq_n;
  logic                     rd_n;
  logic                     wr_n;
  logic                     m1_n;
  zxuno_bus_pkg::cpu_data_t cpu_din;
  logic                     bdir;
  logic                     bc1;

  // Expected response of the bus cycle under way
  logic                     sample;
  logic [127:0]             test_name;
  zxuno_bus_pkg::cpu_data_t exp_din;
  logic                     exp_bdir;
  logic                     exp_bc1;
  int                       pass_count;
  int                       fail_count;

  // Test table from the data file
  logic [127:0]             name_mem [MAX_TESTS];
  logic [1:0]               op_mem   [MAX_TESTS];
  zxuno_bus_pkg::cpu_addr_t addr_mem [MAX_TESTS];
  zxuno_bus_pkg::cpu_data_t data_mem [MAX_TESTS];
  zxuno_bus_pkg::cpu_data_t din_mem  [MAX_TESTS];
  logic                     bdir_mem [MAX_TESTS];
  logic                     bc1_mem  [MAX_TESTS];
  int                       num_tests;
  int                       bad_lines;
  logic                     tests_loaded;

  always #50 sysclk = ~sysclk;

  zxuno_io_top zxuno_io_top_i (
    .sysclk   (sysclk  ),
    .rst_n    (rst_n   ),
    .cpu_addr (cpu_addr),
    .cpu_dout (cpu_dout),
    .iorq_n   (iorq_n  ),
    .rd_n     (rd_n    ),
    .wr_n     (wr_n    ),
    .m1_n     (m1_n    ),
    .cpu_din  (cpu_din ),
    .bdir     (bdir    ),
    .bc1      (bc1     )
  );

  zxuno_io_checker zxuno_io_checker_i (
    .sysclk     (sysclk    ),
    .sample     (sample    ),
    .test_name  (test_name ),
    .exp_din    (exp_din   ),
    .exp_bdir   (exp_bdir  ),
    .exp_bc1    (exp_bc1   ),
    .cpu_din    (cpu_din   ),
    .bdir       (bdir      ),
    .bc1        (bc1       ),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  bind zxuno_io_top zxuno_io_assert zxuno_io_assert_i (
    .sysclk     (sysclk           ),
    .rst_n      (rst_n            ),
    .iorq_n     (iorq_n           ),
    .reg_wr     (reg_wr           ),
    .disable_ay (devopt.disable_ay),
    .bdir       (bdir             ),
    .bc1        (bc1              )
  );

  // ------------------------------------------------------------
  // Data file reader
  // ------------------------------------------------------------
  task automatic load_tests();
    int           fd;
    int           fields;
    string        line;
    logic [127:0] name_v;
    logic [31:0]  op_v;
    logic [15:0]  addr_v;
    logic [7:0]   data_v;
    logic [7:0]   din_v;
    logic         bdir_v;
    logic         bc1_v;
    logic [1:0]   op_code;
    logic         op_ok;
    fd = $fopen("verif/zxuno_io_tests.txt", "r");
    if (fd == 0) begin
      bad_lines = bad_lines + 1;
      $display("cannot open the test table verif/zxuno_io_tests.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      fields = $fgets(line, fd);
      if (fields != 0 && line.len() > 1 && line[0] != "#") begin
        fields = $sscanf(line, "%s %s %h %h %h %h %h",
                         name_v, op_v, addr_v, data_v, din_v, bdir_v, bc1_v);
        op_ok   = 1'b1;
        op_code = OP_IDLE;
        case (op_v)
          32'("wr"):   op_code = OP_WR;
          32'("rd"):   op_code = OP_RD;
          32'("ack"):  op_code = OP_ACK;
          32'("idle"): op_code = OP_IDLE;
          default:     op_ok = 1'b0;
        endcase
        if (fields != 7 || !op_ok || num_tests >= MAX_TESTS) begin
          bad_lines = bad_lines + 1;
          $display("unusable test line: %0s", line);
        end else begin
          name_mem[num_tests] = name_v;
          op_mem[num_tests]   = op_code;
          addr_mem[num_tests] = addr_v;
          data_mem[num_tests] = data_v;
          din_mem[num_tests]  = din_v;
          bdir_mem[num_tests] = bdir_v;
          bc1_mem[num_tests]  = bc1_v;
          num_tests = num_tests + 1;
        end
      end
    end
    $fclose(fd);
  endtask

  // Writes keep iorq_n and wr_n low over both clocks of the cycle
  // Other cycles end iorq_n after one clock while rd_n stays low as in a memory read
  // Acknowledge also drops rd_n so a register read competes with it
  task automatic drive_bus_cycle(input int idx);
    @(negedge sysclk);
    cpu_addr  <= addr_mem[idx];
    cpu_dout  <= data_mem[idx];
    iorq_n    <= (op_mem[idx] == OP_IDLE);
    rd_n      <= !(op_mem[idx] == OP_RD || op_mem[idx] == OP_ACK);
    wr_n      <= (op_mem[idx] != OP_WR);
    m1_n      <= (op_mem[idx] != OP_ACK);
    test_name <= name_mem[idx];
    exp_din   <= din_mem[idx];
    exp_bdir  <= bdir_mem[idx];
    exp_bc1   <= bc1_mem[idx];
    sample    <= 1'b1;
    @(negedge sysclk);
    sample <= 1'b0;
    if (op_mem[idx] != OP_WR) begin
      iorq_n <= 1'b1;
      m1_n   <= 1'b1;
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin : main
    rst_n        = 1'b0;
    cpu_addr     = '0;
    cpu_dout     = '0;
    iorq_n       = 1'b1;
    rd_n         = 1'b1;
    wr_n         = 1'b1;
    m1_n         = 1'b1;
    sample       = 1'b0;
    test_name    = '0;
    exp_din      = '0;
    exp_bdir     = 1'b0;
    exp_bc1      = 1'b0;
    num_tests    = 0;
    bad_lines    = 0;
    tests_loaded = 1'b0;
    load_tests();
    tests_loaded = 1'b1;
    repeat (3) @(negedge sysclk);
    rst_n <= 1'b1;
    for (int i = 0; i < num_tests; i++) begin
      drive_bus_cycle(i);
    end
    // Let the checker count the last cycle
    @(negedge sysclk);
    $display("tests %0d, passed %0d, failed %0d, bad lines %0d, assertion failures %0d",
             num_tests, pass_count, fail_count, bad_lines,
             zxuno_io_top_i.zxuno_io_assert_i.violations);
    if (num_tests > 0 && fail_count == 0 && pass_count == num_tests && bad_lines == 0 &&
        zxuno_io_top_i.zxuno_io_assert_i.violations == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Two clocks per test plus reset and slack
  initial begin : watchdog
    int limit_ns;
    wait (tests_loaded);
    limit_ns = (num_tests * 2 + 20) * 100;
    #(limit_ns);
    $display("timeout: the tests did not finish within %0d ns", limit_ns);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== verif/zxuno_io_tests.txt ====
# name          op    addr  data  din  bdir bc1
# addr, data and din in hex; op is wr, rd, ack or idle
rst_regnum      rd    FC3B  00    00   0    0
rd_unmapped     rd    1234  00    FF   0    0
idle_bus        idle  0000  00    FF   0    0
sel_devopt      wr    FC3B  0E    FF   0    0
rst_devopt      rd    FD3B  00    00   0    0
sel_scratch     wr    FC3B  FE    FF   0    0
rd_regnum       rd    FC3B  00    FE   0    0
rst_scratch     rd    FD3B  00    00   0    0
wr_scratch      wr    FD3B  A5    FF   0    0
rd_scratch      rd    FD3B  00    A5   0    0
ack_addr        ack   FC3B  00    FF   0    0
ack_data        ack   FD3B  00    FF   0    0
sel_devopt2     wr    FC3B  0E    FF   0    0
wr_devopt_dis   wr    FD3B  5B    FF   0    0
rd_devopt_dis   rd    FD3B  00    5B   0    0
dis_fffd        wr    FFFD  07    FF   0    0
dis_bffd        wr    BFFD  3C    FF   0    0
dis_f5          wr    00F5  07    FF   0    0
dis_f6          wr    00F6  3C    FF   0    0
wr_devopt_en    wr    FD3B  A4    FF   0    0
rd_devopt_en    rd    FD3B  00    A4   0    0
ay_wr_fffd      wr    FFFD  07    FF   1    1
ay_wr_bffd      wr    BFFD  3C    FF   1    0
ay_rd_fffd      rd    FFFD  00    FF   0    1
ay_wr_f5        wr    00F5  07    FF   1    1
ay_wr_f6        wr    00F6  3C    FF   1    0
ay_rd_f6        rd    00F6  00    FF   0    1
ay_other        wr    7FFD  10    FF   0    0
sel_coreid      wr    FC3B  FF    FF   0    0
id_char0        rd    FD3B  00    5A   0    0
id_char1        rd    FD3B  00    58   0    0
id_char2        rd    FD3B  00    49   0    0
id_char3        rd    FD3B  00    4F   0    0
id_char4        rd    FD3B  00    2D   0    0
id_char5        rd    FD3B  00    30   0    0
id_char6        rd    FD3B  00    31   0    0
id_term         rd    FD3B  00    00   0    0
id_wrap         rd    FD3B  00    5A   0    0
resel_coreid    wr    FC3B  FF    FF   0    0
id_restart      rd    FD3B  00    5A   0    0

// ==== vlog.f ====
+incdir+logic
logic/zxuno_bus_pkg.sv
logic/zxuno_cfg_pkg.sv
logic/zxuno_regaddr.sv
logic/zxuno_cfg_reg.sv
logic/coreid_rom.sv
logic/ay_bus_ctrl.sv
logic/zxuno_io_top.sv
verif/zxuno_io_assert.sv
verif/zxuno_io_checker.sv
verif/zxuno_io_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module zxuno_io_tb -f vlog.f -o zxuno_io_sim

./obj_dir/zxuno_io_sim | tee sim.log

# The log decides the result
if grep -qx "sim passed" sim.log; then
  echo "run_sim: PASS"
else
  echo "run_sim: FAIL, see sim.log"
  exit 1
fi
